// ==== files.f ====
design/core_pkg.sv
design/core_stage_if.sv
design/core_fetch.sv
design/core_decode.sv
design/core_regfile.sv
design/core_execute.sv
design/core_control.sv
design/core_top.sv
bench/core_chk.sv
bench/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module core_tb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vcore_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Pass only on an exact pass line
if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// ==== bench/core_tb.sv ====
`default_nettype none

module core_tb import core_pkg::*;
();

  logic            clk;
  logic            rst;
  logic            if_req;
  word_t           if_nxt_pc;
  logic            if_parcel_valid = 1'b0;
  logic [ilen-1:0] if_parcel = '0;
  word_t           if_parcel_pc = '0;
  logic            wb_valid;
  word_t           wb_pc;
  logic            wb_we;
  reg_addr_t       wb_dst;
  word_t           wb_value;

  // Program image at pc_init, one word per entry
  logic [31:0] imem [0:255];
  // Reference machine state
  word_t       m_regs [0:31];
  word_t       m_pc;
  logic [15:0] rng_state;
  // Request seen on the previous falling edge
  logic        req_q = 1'b0;
  word_t       req_pc_q = '0;
  int          n_val_err;
  int          n_reg_err;
  int          n_bit_err;
  int          n_stall;
  int          retired;
  int          idle;

  core_top dut_i
  (
    .clk             (clk),
    .rst             (rst),
    .if_req          (if_req),
    .if_nxt_pc       (if_nxt_pc),
    .if_parcel_valid (if_parcel_valid),
    .if_parcel       (if_parcel),
    .if_parcel_pc    (if_parcel_pc),
    .wb_valid        (wb_valid),
    .wb_pc           (wb_pc),
    .wb_we           (wb_we),
    .wb_dst          (wb_dst),
    .wb_value        (wb_value)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // Random source
  ////////////////////

  // 16-bit Fibonacci, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] draw(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      rng_state = lfsr_next(rng_state);
      v = {v[30:0], rng_state[0]};
    end
    return v;
  endfunction

  ////////////////////
  // Encoders
  ////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic [2:0] f3,
                                        input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                        input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  // Out of range reads give a nop, never accepted by the core
  function automatic logic [31:0] fetch_word(input word_t addr);
    word_t off;
    off = addr - pc_init;
    if (off < word_t'(1024))
      return imem[off[9:2]];
    return 32'h0000_0013;
  endfunction

  task automatic build_program();
    int          i;
    logic [2:0]  kind;
    logic [2:0]  sel;
    logic [2:0]  f3;
    logic [6:0]  f7;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    // x1 to x7 get defined values before any read
    for (i = 1; i < 8; i++)
      imem[8'(i - 1)] = enc_i(12'(draw(12)), 5'd0, 3'b000, 5'(i));
    for (i = 7; i < 248; i++)
    begin
      kind = 3'(draw(3));
      rd   = reg_addr_t'(draw(3));
      rs1  = reg_addr_t'(draw(3));
      rs2  = reg_addr_t'(draw(3));
      sel  = 3'(draw(3));
      f7   = (sel == 3'd1) ? 7'h20 : 7'h00;
      case (sel)
        3'd0, 3'd1: f3 = 3'b000;
        3'd2:       f3 = 3'b010;
        3'd3:       f3 = 3'b100;
        3'd4:       f3 = 3'b110;
        default:    f3 = 3'b111;
      endcase
      case (kind)
        3'd0, 3'd1: imem[8'(i)] = enc_r(f7, rs2, rs1, f3, rd);
        3'd2, 3'd3: imem[8'(i)] = enc_i(12'(draw(12)), rs1, f3, rd);
        3'd4:       imem[8'(i)] = {20'(draw(20)), rd, opc_lui};
        // Forward hops of 4 to 32 bytes
        3'd5:       imem[8'(i)] = enc_b(13'((draw(3) + 1) * 4), rs2, rs1, 3'b000);
        3'd6:       imem[8'(i)] = enc_b(13'((draw(3) + 1) * 4), rs2, rs1, 3'b001);
        default:    imem[8'(i)] = enc_j(21'((draw(3) + 1) * 4), rd);
      endcase
    end
    // Tail spins on a jump to itself
    for (i = 248; i < 256; i++)
      imem[8'(i)] = enc_j(21'd0, 5'd0);
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return a + b;
    endcase
  endfunction

  // Executes one instruction in program order
  task automatic model_step(output word_t pc_o, output logic we_o, output reg_addr_t rd_o,
                            output word_t val_o);
    logic [31:0] ins;
    word_t       a;
    word_t       b;
    word_t       nxt;
    logic [2:0]  f3;
    ins   = fetch_word(m_pc);
    a     = m_regs[ins[19:15]];
    b     = m_regs[ins[24:20]];
    f3    = ins[14:12];
    pc_o  = m_pc;
    we_o  = 1'b0;
    rd_o  = ins[11:7];
    val_o = '0;
    nxt   = m_pc + 32'd4;
    case (ins[6:0])
      opc_op:
      begin
        we_o  = 1'b1;
        val_o = alu_ref(f3, ins[30], a, b);
      end
      opc_op_imm:
      begin
        we_o  = 1'b1;
        val_o = alu_ref(f3, 1'b0, a, {{20{ins[31]}}, ins[31:20]});
      end
      opc_lui:
      begin
        we_o  = 1'b1;
        val_o = {ins[31:12], 12'b0};
      end
      opc_branch:
      begin
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
          nxt = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      opc_jal:
      begin
        we_o  = 1'b1;
        val_o = m_pc + 32'd4;
        nxt   = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default:
      begin
        we_o = 1'b0;
      end
    endcase
    // x0 stays zero
    if (we_o && rd_o != 5'd0)
      m_regs[rd_o] = val_o;
    m_pc = nxt;
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      n_val_err++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
    begin
      n_reg_err++;
      $display("ERR %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      n_bit_err++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic retire_check();
    word_t     e_pc;
    logic      e_we;
    reg_addr_t e_rd;
    word_t     e_val;
    model_step(e_pc, e_we, e_rd, e_val);
    check_word("retired pc", wb_pc, e_pc);
    check_bit("write enable", wb_we, e_we);
    // Branches carry no destination
    if (e_we)
    begin
      check_reg("destination", wb_dst, e_rd);
      check_word("write value", wb_value, e_val);
    end
  endtask

  // Instruction memory, answers one cycle after the request
  always @(negedge clk)
  begin
    if_parcel_valid = req_q;
    if_parcel_pc    = req_pc_q;
    if_parcel       = fetch_word(req_pc_q);
    req_q           = if_req;
    req_pc_q        = if_nxt_pc;
  end

  initial
  begin
    rst       = 1'b1;
    n_val_err = 0;
    n_reg_err = 0;
    n_bit_err = 0;
    n_stall   = 0;
    retired   = 0;
    idle      = 0;
    rng_state = 16'd92;
    m_pc      = pc_init;
    for (int k = 0; k < 32; k++)
      m_regs[5'(k)] = '0;
    build_program();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (retired < 400 && n_stall == 0)
    begin
      @(negedge clk);
      if (wb_valid)
      begin
        retire_check();
        retired++;
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle >= 50)
        begin
          n_stall++;
          $display("The core stopped retiring: no retirement for 50 cycles after %0d",
                   retired);
        end
      end
    end
    $display("errors: value %0d, register %0d, enable %0d, stalls %0d",
             n_val_err, n_reg_err, n_bit_err, n_stall);
    if (n_val_err + n_reg_err + n_bit_err + n_stall == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/core_chk.sv ====
`default_nettype none

// Pipeline control properties, bound into every core_control
module core_chk import core_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      taken,
  input logic      flush,
  input logic      ex_we,
  input reg_addr_t ex_dst,
  input byp_sel_e  byp_a
);

  // Second squash cycle after a redirect
  flush_after_taken: assert property (@(posedge clk) disable iff (rst) taken |=> flush)
    else $error("flush missing in the cycle after taken");

  // EX bypass only from a live writer other than x0
  ex_bypass_live: assert property (@(posedge clk) disable iff (rst)
    (byp_a == byp_ex) |-> (ex_we && ex_dst != 5'd0))
    else $error("operand A bypassed from EX without a valid nonzero destination");

  // No redirect straight out of reset
  quiet_in_reset: assert property (@(posedge clk) rst |=> !taken)
    else $error("taken raised while in reset");

endmodule

bind core_control core_chk chk_i
(
  .clk    (clk),
  .rst    (rst),
  .taken  (taken),
  .flush  (flush),
  .ex_we  (ex_we),
  .ex_dst (ex_dst),
  .byp_a  (byp_a)
);

`default_nettype wire

// ==== design/core_top.sv ====
`default_nettype none

module core_top import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  // Instruction bus
  output logic            if_req,
  output word_t           if_nxt_pc,
  input  logic            if_parcel_valid,
  input  logic [ilen-1:0] if_parcel,
  input  word_t           if_parcel_pc,
  // Retire report
  output logic            wb_valid,
  output word_t           wb_pc,
  output logic            wb_we,
  output reg_addr_t       wb_dst,
  output word_t           wb_value
);

  ////////////////////
  // Wires
  ////////////////////

  // IF to ID
  logic            fe_valid;
  logic [ilen-1:0] fe_instr;
  word_t           fe_pc;
  // Redirect and squash
  logic            taken;
  word_t           redirect_pc;
  logic            flush;
  // Register file reads
  reg_addr_t       rs1;
  reg_addr_t       rs2;
  word_t           rdata1;
  word_t           rdata2;
  // Bypass
  byp_sel_e        byp_a;
  byp_sel_e        byp_b;
  word_t           ex_fwd;
  reg_addr_t       ex_dst;
  logic            ex_we;

  // ID to EX bundle
  core_stage_if stage ();

  ////////////////////
  // Units
  ////////////////////

  core_fetch   fetch_unit (.*);

  core_decode  decode_unit (.wb_fwd (wb_value), .*);

  core_execute exec_unit (.*);

  core_control ctrl_unit (.*);

  // Written from the WB register
  core_regfile int_rf (.we (wb_we), .waddr (wb_dst), .wdata (wb_value), .*);

endmodule

`default_nettype wire

// ==== design/core_control.sv ====
`default_nettype none

module core_control import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t ex_dst,
  input  logic      ex_we,
  input  reg_addr_t wb_dst,
  input  logic      wb_we,
  input  logic      taken,
  output byp_sel_e  byp_a,
  output byp_sel_e  byp_b,
  output logic      flush
);

  // Second flush cycle
  logic flush_q;

  // EX result beats WB, x0 never forwards
  function automatic byp_sel_e sel_src(input reg_addr_t rs, input reg_addr_t exd,
                                       input logic exw, input reg_addr_t wbd,
                                       input logic wbw);
    if (exw && exd != 5'd0 && exd == rs)
      return byp_ex;
    else if (wbw && wbd != 5'd0 && wbd == rs)
      return byp_wb;
    else
      return byp_rf;
  endfunction

  ////////////////////
  // Bypass select
  ////////////////////

  assign byp_a = sel_src(rs1, ex_dst, ex_we, wb_dst, wb_we);
  assign byp_b = sel_src(rs2, ex_dst, ex_we, wb_dst, wb_we);

  ////////////////////
  // Flush
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      flush_q <= 1'b0;
    else
      flush_q <= taken & ~flush_q;
  end

  // ID and the current parcel now, the in-flight parcel next cycle
  assign flush = taken | flush_q;

endmodule

`default_nettype wire

// ==== design/core_execute.sv ====
`default_nettype none

module core_execute import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  core_stage_if.dst stage,
  output reg_addr_t ex_dst,
  output logic      ex_we,
  output word_t     ex_fwd,
  output logic      taken,
  output word_t     redirect_pc,
  output logic      wb_valid,
  output logic      wb_we,
  output reg_addr_t wb_dst,
  output word_t     wb_value,
  output word_t     wb_pc
);

  logic      ex_valid;
  word_t     ex_pc;
  alu_op_e   ex_alu_op;
  br_kind_e  ex_br_kind;
  reg_addr_t ex_rd;
  logic      ex_rd_we;
  word_t     ex_opa;
  word_t     ex_opb;
  word_t     ex_target;
  word_t     alu_res;
  logic      op_eq;

  ////////////////////
  // EX register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      ex_valid <= 1'b0;
    else
      ex_valid <= stage.valid;
  end

  // Payload follows the bus every cycle
  always_ff @(posedge clk)
  begin
    ex_pc      <= stage.pc;
    ex_alu_op  <= stage.alu_op;
    ex_br_kind <= stage.br_kind;
    ex_rd      <= stage.rd;
    ex_rd_we   <= stage.we;
    ex_opa     <= stage.opa;
    ex_opb     <= stage.opb;
    ex_target  <= stage.br_target;
  end

  ////////////////////
  // ALU
  ////////////////////

  always_comb
  begin
    case (ex_alu_op)
      alu_sub:    alu_res = ex_opa - ex_opb;
      alu_and:    alu_res = ex_opa & ex_opb;
      alu_or:     alu_res = ex_opa | ex_opb;
      alu_xor:    alu_res = ex_opa ^ ex_opb;
      alu_slt:    alu_res = ($signed(ex_opa) < $signed(ex_opb)) ? word_t'(1) : '0;
      alu_pass_b: alu_res = ex_opb;
      default:    alu_res = ex_opa + ex_opb;
    endcase
  end

  // JAL links the return address instead
  assign ex_fwd = (ex_br_kind == br_jal) ? ex_pc + word_t'(4) : alu_res;

  // Branch resolution
  assign op_eq       = (ex_opa == ex_opb);
  assign taken       = ex_valid & ((ex_br_kind == br_jal) |
                                   (ex_br_kind == br_beq &  op_eq) |
                                   (ex_br_kind == br_bne & ~op_eq));
  assign redirect_pc = ex_target;

  // Producer info for the bypass
  assign ex_dst = ex_rd;
  assign ex_we  = ex_valid & ex_rd_we;

  ////////////////////
  // WB register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wb_valid <= 1'b0;
      wb_we    <= 1'b0;
    end
    else
    begin
      wb_valid <= ex_valid;
      wb_we    <= ex_we;
    end
  end

  // Retire payload, also the RF write data
  always_ff @(posedge clk)
  begin
    wb_dst   <= ex_rd;
    wb_value <= ex_fwd;
    wb_pc    <= ex_pc;
  end

endmodule

`default_nettype wire

// ==== design/core_regfile.sv ====
`default_nettype none

module core_regfile import core_pkg::*;
(
  input  logic      clk,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  output word_t     rdata1,
  output word_t     rdata2,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  // x1 to x31, x0 has no storage
  word_t regs [1:31];

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk)
  begin
    // Writes to x0 are dropped
    if (we && waddr != 5'd0)
      regs[waddr] <= wdata;
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Asynchronous, old value during a write
  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== design/core_decode.sv ====
`default_nettype none

module core_decode import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            fe_valid,
  input  logic [ilen-1:0] fe_instr,
  input  word_t           fe_pc,
  input  logic            flush,
  output reg_addr_t       rs1,
  output reg_addr_t       rs2,
  input  word_t           rdata1,
  input  word_t           rdata2,
  input  byp_sel_e        byp_a,
  input  byp_sel_e        byp_b,
  input  word_t           ex_fwd,
  input  word_t           wb_fwd,
  core_stage_if.src       stage
);

  logic            id_valid;
  logic [ilen-1:0] id_instr;
  word_t           id_pc;
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  word_t           imm_i;
  word_t           imm_u;
  word_t           imm_b;
  word_t           imm_j;
  word_t           imm_sel;
  logic            use_imm;
  word_t           src_a;
  word_t           src_b;
  alu_op_e         alu_op;
  br_kind_e        br_kind;
  logic            we;

  // funct3 to ALU function, shared by OP and OP-IMM
  function automatic alu_op_e f3_op(input logic [2:0] f3);
    case (f3)
      3'b010:  return alu_slt;
      3'b100:  return alu_xor;
      3'b110:  return alu_or;
      3'b111:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  // Bypass mux for one source
  function automatic word_t pick(input byp_sel_e sel, input word_t rf, input word_t ex,
                                 input word_t wb);
    case (sel)
      byp_ex:  return ex;
      byp_wb:  return wb;
      default: return rf;
    endcase
  endfunction

  ////////////////////
  // ID register
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      id_valid <= 1'b0;
    else
      id_valid <= fe_valid & ~flush;
  end

  // Payload, loaded with each accepted parcel
  always_ff @(posedge clk)
  begin
    if (fe_valid)
    begin
      id_instr <= fe_instr;
      id_pc    <= fe_pc;
    end
  end

  ////////////////////
  // Field decode
  ////////////////////

  assign opcode = opcode_e'(id_instr[6:0]);
  assign funct3 = id_instr[14:12];
  assign funct7 = id_instr[31:25];
  assign rs1    = id_instr[19:15];
  assign rs2    = id_instr[24:20];

  // Immediates, all sign extended from bit 31
  assign imm_i = {{20{id_instr[31]}}, id_instr[31:20]};
  assign imm_u = {id_instr[31:12], 12'b0};
  assign imm_b = {{19{id_instr[31]}}, id_instr[31], id_instr[7], id_instr[30:25],
                  id_instr[11:8], 1'b0};
  assign imm_j = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12], id_instr[20],
                  id_instr[30:21], 1'b0};

  always_comb
  begin
    // Unknown encodings fall through as a no-op
    alu_op  = alu_add;
    br_kind = br_none;
    we      = 1'b0;
    use_imm = 1'b0;
    imm_sel = imm_i;
    case (opcode)
      opc_op:
      begin
        we     = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        alu_op = (funct3 == 3'b000 && funct7[5]) ? alu_sub : f3_op(funct3);
      end
      opc_op_imm:
      begin
        we      = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        alu_op  = f3_op(funct3);
        use_imm = 1'b1;
      end
      opc_lui:
      begin
        we      = 1'b1;
        alu_op  = alu_pass_b;
        use_imm = 1'b1;
        imm_sel = imm_u;
      end
      opc_branch:
      begin
        // Only BEQ and BNE are implemented
        if (funct3 == 3'b000)
          br_kind = br_beq;
        else if (funct3 == 3'b001)
          br_kind = br_bne;
      end
      opc_jal:
      begin
        we      = 1'b1;
        br_kind = br_jal;
      end
      default:
      begin
        we = 1'b0;
      end
    endcase
  end

  // Operand values, newest producer first
  assign src_a = pick(byp_a, rdata1, ex_fwd, wb_fwd);
  assign src_b = pick(byp_b, rdata2, ex_fwd, wb_fwd);

  ////////////////////
  // To EX
  ////////////////////

  assign stage.valid     = id_valid & ~flush;
  assign stage.pc        = id_pc;
  assign stage.alu_op    = alu_op;
  assign stage.br_kind   = br_kind;
  assign stage.rd        = id_instr[11:7];
  assign stage.we        = we;
  assign stage.opa       = src_a;
  assign stage.opb       = use_imm ? imm_sel : src_b;
  // JAL and branches use different offset layouts
  assign stage.br_target = id_pc + ((br_kind == br_jal) ? imm_j : imm_b);

endmodule

`default_nettype wire

// ==== design/core_fetch.sv ====
`default_nettype none

module core_fetch import core_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            taken,
  input  word_t           redirect_pc,
  input  logic            flush,
  output logic            if_req,
  output word_t           if_nxt_pc,
  input  logic            if_parcel_valid,
  input  logic [ilen-1:0] if_parcel,
  input  word_t           if_parcel_pc,
  output logic            fe_valid,
  output logic [ilen-1:0] fe_instr,
  output word_t           fe_pc
);

  // Address of the next request
  word_t req_pc;
  // Address the next useful parcel must carry
  word_t exp_pc;
  logic  accept;

  // Parcel is in sequence and not squashed
  assign accept = if_parcel_valid & (if_parcel_pc == exp_pc) & ~flush;

  ////////////////////
  // PC registers
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      if_req <= 1'b0;
      req_pc <= pc_init;
      exp_pc <= pc_init;
    end
    else
    begin
      // Requests run every cycle once out of reset
      if_req <= 1'b1;
      if (taken)
      begin
        // Restart both streams at the target
        req_pc <= redirect_pc;
        exp_pc <= redirect_pc;
      end
      else
      begin
        if (if_req)
          req_pc <= req_pc + word_t'(4);
        // Step only when the expected parcel shows up
        if (accept)
          exp_pc <= exp_pc + word_t'(4);
      end
    end
  end

  assign if_nxt_pc = req_pc;

  // To ID, stale or squashed parcels are dropped here
  assign fe_valid  = accept;
  assign fe_instr  = if_parcel;
  assign fe_pc     = if_parcel_pc;

endmodule

`default_nettype wire

// ==== design/core_stage_if.sv ====
`default_nettype none

// One decoded instruction on its way from ID to EX
interface core_stage_if import core_pkg::*;
();

  // Strobe, one per instruction
  logic     valid;
  word_t    pc;
  alu_op_e  alu_op;
  br_kind_e br_kind;
  // Destination register and its write enable
  reg_addr_t rd;
  logic      we;
  // Operands after bypass and immediate select
  word_t    opa;
  word_t    opb;
  // Branch or jump destination
  word_t    br_target;

  ////////////////////
  // Views
  ////////////////////

  // Decode side
  modport src (output valid, pc, alu_op, br_kind, rd, we, opa, opb, br_target);

  // Execute side
  modport dst (input valid, pc, alu_op, br_kind, rd, we, opa, opb, br_target);

endinterface

`default_nettype wire

// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data and address width
  localparam int xlen = 32;
  // Instruction parcel width
  localparam int ilen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] word_t;

  // First fetch address after reset
  localparam word_t pc_init = 32'h0000_0200;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_e;

  // ALU functions
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  // Control transfer kind, resolved in EX
  typedef enum logic [1:0] {
    br_none,
    br_beq,
    br_bne,
    br_jal
  } br_kind_e;

  // Operand source picked by the bypass logic
  typedef enum logic [1:0] {
    byp_rf,
    byp_ex,
    byp_wb
  } byp_sel_e;

endpackage

`default_nettype wire
